// ==== src/boy_bus_pkg.sv ====
package boy_bus_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    localparam int ADDR_W = 16;   // CPU address bus
    localparam int DATA_W = 8;    // Byte wide data path
    localparam int INT_N  = 5;    // VBlank, STAT, timer, serial, joypad

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    //////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////

    // Single byte registers on the internal bus
    localparam addr_t ADDR_IE = 16'hFFFF;   // Interrupt enable
    localparam addr_t ADDR_IF = 16'hFF0F;   // Interrupt flags
    localparam addr_t ADDR_DMA = 16'hFF46;  // Sprite DMA source page

    // High RAM window, IE sits on its last byte
    localparam addr_t HRAM_BASE = 16'hFF80;

    // Sprite attribute table, destination of every DMA copy
    localparam addr_t OAM_BASE = 16'hFE00;

    // Anything not matched above goes out on the cartridge side

endpackage

// ==== src/sys_bus_if.sv ====
`timescale 1ns/10ps

// One request/response link between a master and a target
interface sys_bus_if;

    logic                  valid;  // Request present
    logic                  ready;  // Target done, rdata good
    boy_bus_pkg::addr_t    addr;
    logic                  we;     // 1 = write, 0 = read
    boy_bus_pkg::data_t    wdata;
    boy_bus_pkg::data_t    rdata;

    // Request side, holds everything until ready
    modport master (
        output valid,
        output addr,
        output we,
        output wdata,
        input  ready,
        input  rdata
    );

    // Response side
    modport target (
        input  valid,
        input  addr,
        input  we,
        input  wdata,
        output ready,
        output rdata
    );

endinterface

// ==== src/bus_arbiter.sv ====
`timescale 1ns/10ps

// Two peer masters onto one shared bus, round robin, no preemption
module bus_arbiter (
    input logic       clk,
    input logic       rst,
    sys_bus_if.target m_cpu,   // Processor side
    sys_bus_if.target m_dma,   // Sprite DMA side
    sys_bus_if.master s_bus    // Toward the decoder
);

    logic locked;    // A granted transfer is still open
    logic gnt_dma;   // Owner while locked
    logic last_dma;  // Who finished last
    logic sel_dma;   // Current winner

    //////////////////////////////////////////////////
    // Winner selection
    //////////////////////////////////////////////////

    always_comb begin
        if (locked)
            sel_dma = gnt_dma;                  // Stick with the owner
        else if (m_cpu.valid && m_dma.valid)
            sel_dma = !last_dma;                // Tie goes to the one not served last
        else
            sel_dma = m_dma.valid;              // Lone requester, or cpu by default
    end

    // Winner's request onto the shared bus
    assign s_bus.valid = sel_dma ? m_dma.valid : m_cpu.valid;
    assign s_bus.addr  = sel_dma ? m_dma.addr  : m_cpu.addr;
    assign s_bus.we    = sel_dma ? m_dma.we    : m_cpu.we;
    assign s_bus.wdata = sel_dma ? m_dma.wdata : m_cpu.wdata;

    // Response only to the winner, the loser sees nothing
    assign m_cpu.ready = s_bus.ready && !sel_dma;
    assign m_dma.ready = s_bus.ready && sel_dma;
    assign m_cpu.rdata = sel_dma ? '0 : s_bus.rdata;
    assign m_dma.rdata = sel_dma ? s_bus.rdata : '0;

    //////////////////////////////////////////////////
    // Grant lock
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            locked   <= 1'b0;
            gnt_dma  <= 1'b0;
            last_dma <= 1'b1;                   // First tie favours the processor
        end else if (s_bus.valid && s_bus.ready) begin
            locked   <= 1'b0;                   // Done, free for next cycle
            last_dma <= sel_dma;
        end else if (s_bus.valid) begin
            locked  <= 1'b1;                    // Target stalls, keep the owner
            gnt_dma <= sel_dma;
        end
    end

endmodule

// ==== src/bus_decoder.sv ====
`timescale 1ns/10ps

// Routes the granted request to one internal target or the cartridge port
module bus_decoder #(
    parameter int HRAM_AW = 7
) (
    input  logic                clk,
    input  logic                rst,
    sys_bus_if.target           s_bus,
    sys_bus_if.master           t_hram,
    sys_bus_if.master           t_int,
    sys_bus_if.master           t_dma,
    output logic                ext_valid,
    output boy_bus_pkg::addr_t  ext_addr,
    output logic                ext_we,
    output boy_bus_pkg::data_t  ext_wdata,
    input  boy_bus_pkg::data_t  ext_rdata,
    input  logic                ext_ready
);

    logic hit_hram;
    logic hit_int;
    logic hit_dma;
    logic hit_ext;
    logic pending;   // Internal target already saw its pulse
    logic issue;     // First cycle of an internal request

    //////////////////////////////////////////////////
    // Address match
    //////////////////////////////////////////////////

    always_comb begin
        // Top bits against the window base, IE carved out of the last byte
        hit_hram = ((s_bus.addr >> HRAM_AW) == (boy_bus_pkg::HRAM_BASE >> HRAM_AW))
                   && (s_bus.addr != boy_bus_pkg::ADDR_IE);
        hit_int  = (s_bus.addr == boy_bus_pkg::ADDR_IE) ||
                   (s_bus.addr == boy_bus_pkg::ADDR_IF);
        hit_dma  = (s_bus.addr == boy_bus_pkg::ADDR_DMA);
        hit_ext  = !(hit_hram || hit_int || hit_dma);
    end

    assign issue = s_bus.valid && !pending;

    // One-cycle valid pulse per internal transfer
    assign t_hram.valid = issue && hit_hram;
    assign t_int.valid  = issue && hit_int;
    assign t_dma.valid  = issue && hit_dma;

    // Request fields fan out unchanged, valid does the selecting
    assign t_hram.addr  = s_bus.addr;
    assign t_hram.we    = s_bus.we;
    assign t_hram.wdata = s_bus.wdata;
    assign t_int.addr   = s_bus.addr;
    assign t_int.we     = s_bus.we;
    assign t_int.wdata  = s_bus.wdata;
    assign t_dma.addr   = s_bus.addr;
    assign t_dma.we     = s_bus.we;
    assign t_dma.wdata  = s_bus.wdata;

    // Cartridge side follows the bus combinationally
    assign ext_valid = s_bus.valid && hit_ext;
    assign ext_addr  = s_bus.addr;
    assign ext_we    = s_bus.we;
    assign ext_wdata = s_bus.wdata;

    // Response mux
    always_comb begin
        if (hit_ext) begin
            s_bus.ready = ext_valid && ext_ready;   // Variable wait states
            s_bus.rdata = ext_rdata;
        end else if (hit_hram) begin
            s_bus.ready = t_hram.ready;
            s_bus.rdata = t_hram.rdata;
        end else if (hit_int) begin
            s_bus.ready = t_int.ready;
            s_bus.rdata = t_int.rdata;
        end else begin
            s_bus.ready = t_dma.ready;
            s_bus.rdata = t_dma.rdata;
        end
    end

    // Internal targets answer exactly one cycle after the pulse
    always_ff @(posedge clk) begin
        if (rst)
            pending <= 1'b0;
        else
            pending <= issue && !hit_ext;
    end

endmodule

// ==== src/high_ram.sv ====
`timescale 1ns/10ps

// Zero page RAM, FF80 up to FFFE
module high_ram #(
    parameter int HRAM_AW = 7
) (
    input logic       clk,
    input logic       rst,
    sys_bus_if.target bus
);

    boy_bus_pkg::data_t mem [2**HRAM_AW];  // No reset, defined once written
    boy_bus_pkg::data_t rd_q;               // Read data, lines up with ready
    logic               ack;

    logic [HRAM_AW-1:0] idx;
    assign idx = bus.addr[HRAM_AW-1:0];     // Low bits pick the byte

    // Storage
    always_ff @(posedge clk) begin
        if (bus.valid)
            rd_q <= mem[idx];               // Sampled on the request pulse
        if (ack && bus.we)
            mem[idx] <= bus.wdata;          // Write lands on the ready cycle
    end

    // Response one cycle after the pulse
    always_ff @(posedge clk) begin
        if (rst)
            ack <= 1'b0;
        else
            ack <= bus.valid;
    end

    assign bus.ready = ack;
    assign bus.rdata = rd_q;

endmodule

// ==== src/int_ctrl.sv ====
`timescale 1ns/10ps

// IE at FFFF and IF at FF0F, plus the pending interrupt encoder
module int_ctrl (
    input  logic                                 clk,
    input  logic                                 rst,
    sys_bus_if.target                            bus,
    input  logic [boy_bus_pkg::INT_N-1:0]        int_req,  // One-cycle pulses
    output logic                                 irq,
    output logic [2:0]                           irq_id
);

    logic [boy_bus_pkg::INT_N-1:0] ie_r;
    logic [boy_bus_pkg::INT_N-1:0] if_r;
    logic [boy_bus_pkg::INT_N-1:0] act;    // Enabled and flagged
    boy_bus_pkg::data_t            rd_q;
    logic                          ack;
    logic                          sel_ie; // Else IF, decoder sends nothing else
    logic                          ie_ok;  // IE written since reset
    logic                          if_ok;  // IF written since reset
    logic                          wr_ie;
    logic                          wr_if;

    assign sel_ie = (bus.addr == boy_bus_pkg::ADDR_IE);
    assign wr_ie  = ack && bus.we && sel_ie;
    assign wr_if  = ack && bus.we && !sel_ie;

    //////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_ie)
            ie_r <= bus.wdata[boy_bus_pkg::INT_N-1:0];
        if (wr_if)
            if_r <= bus.wdata[boy_bus_pkg::INT_N-1:0] | int_req;  // Request not lost
        else
            if_r <= if_r | int_req;                               // Latch pulses
        if (bus.valid)
            rd_q <= boy_bus_pkg::data_t'(sel_ie ? ie_r : if_r);   // Top bits read 0
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack   <= 1'b0;
            ie_ok <= 1'b0;
            if_ok <= 1'b0;
        end else begin
            ack <= bus.valid;
            if (wr_ie)
                ie_ok <= 1'b1;
            if (wr_if)
                if_ok <= 1'b1;
        end
    end

    assign bus.ready = ack;
    assign bus.rdata = rd_q;

    //////////////////////////////////////////////////
    // Priority, lowest bit wins
    //////////////////////////////////////////////////

    assign act = (ie_ok && if_ok) ? (ie_r & if_r) : '0;
    assign irq = |act;

    always_comb begin
        irq_id = 3'd0;
        for (int i = boy_bus_pkg::INT_N - 1; i >= 0; i--) begin
            if (act[i])
                irq_id = 3'(i);                 // Last hit is the lowest index
        end
    end

endmodule

// ==== src/oam_dma.sv ====
`timescale 1ns/10ps

// Sprite table DMA, copies page XX00.. into FE00.. one byte at a time
module oam_dma #(
    parameter int DMA_LEN = 160
) (
    input  logic      clk,
    input  logic      rst,
    sys_bus_if.target regs,     // FF46
    sys_bus_if.master m_dma,    // Onto the arbiter
    output logic      dma_busy
);

    localparam int IDX_W = (DMA_LEN > 1) ? $clog2(DMA_LEN) : 1;

    boy_bus_pkg::data_t page;    // Source high byte
    boy_bus_pkg::data_t byte_q;  // Byte in flight
    logic [IDX_W-1:0]   idx;
    logic               busy;
    logic               phase;   // 0 read source, 1 write OAM
    logic               reg_ack;
    logic               start;
    logic               xfer;

    // Register port
    assign regs.ready = reg_ack;
    assign regs.rdata = page;
    assign start = reg_ack && regs.we && !busy;  // Writes during a copy are dropped

    //////////////////////////////////////////////////
    // Bus master side
    //////////////////////////////////////////////////

    assign m_dma.valid = busy;
    assign m_dma.we    = phase;
    assign m_dma.wdata = byte_q;
    assign m_dma.addr  = phase
        ? boy_bus_pkg::OAM_BASE + boy_bus_pkg::addr_t'(idx)
        : (boy_bus_pkg::addr_t'(page) << 8) + boy_bus_pkg::addr_t'(idx);

    assign xfer = m_dma.valid && m_dma.ready;

    // Payload
    always_ff @(posedge clk) begin
        if (start)
            page <= regs.wdata;
        if (xfer && !phase)
            byte_q <= m_dma.rdata;                     // Hold for the write half
    end

    // Sequencer
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_ack <= 1'b0;
            busy    <= 1'b0;
            phase   <= 1'b0;
            idx     <= '0;
        end else begin
            reg_ack <= regs.valid;
            if (start) begin
                busy  <= 1'b1;                         // Runs from next cycle
                phase <= 1'b0;
                idx   <= '0;
            end else if (xfer) begin
                if (!phase) begin
                    phase <= 1'b1;
                end else begin
                    phase <= 1'b0;
                    if (idx == IDX_W'(DMA_LEN - 1))
                        busy <= 1'b0;                  // Last write done
                    else
                        idx <= idx + 1'b1;
                end
            end
        end
    end

    assign dma_busy = busy;

endmodule

// ==== src/boy_bus_top.sv ====
`timescale 1ns/10ps

// System bus top, processor and DMA sharing one bus
module boy_bus_top #(
    parameter int HRAM_AW = 7,
    parameter int DMA_LEN = 160
) (
    input  logic                           clk,
    input  logic                           rst,
    // Processor port
    input  logic                           cpu_valid,
    input  boy_bus_pkg::addr_t             cpu_addr,
    input  logic                           cpu_we,
    input  boy_bus_pkg::data_t             cpu_wdata,
    output logic                           cpu_ready,
    output boy_bus_pkg::data_t             cpu_rdata,
    // Cartridge / work memory
    output logic                           ext_valid,
    output boy_bus_pkg::addr_t             ext_addr,
    output logic                           ext_we,
    output boy_bus_pkg::data_t             ext_wdata,
    input  boy_bus_pkg::data_t             ext_rdata,
    input  logic                           ext_ready,
    // Interrupts and status
    input  logic [boy_bus_pkg::INT_N-1:0]  int_req,
    output logic                           irq,
    output logic [2:0]                     irq_id,
    output logic                           dma_busy
);

    sys_bus_if m_cpu ();   // Processor request
    sys_bus_if m_dma ();   // DMA request
    sys_bus_if s_bus ();   // Granted request
    sys_bus_if t_hram ();
    sys_bus_if t_int ();
    sys_bus_if t_dma ();   // FF46 register

    // Processor pins onto its link
    assign m_cpu.valid = cpu_valid;
    assign m_cpu.addr  = cpu_addr;
    assign m_cpu.we    = cpu_we;
    assign m_cpu.wdata = cpu_wdata;
    assign cpu_ready   = m_cpu.ready;
    assign cpu_rdata   = m_cpu.rdata;

    bus_arbiter i_bus_arbiter (.clk, .rst, .m_cpu, .m_dma, .s_bus);

    bus_decoder #(.HRAM_AW(HRAM_AW)) i_bus_decoder (
        .clk, .rst, .s_bus, .t_hram, .t_int, .t_dma,
        .ext_valid, .ext_addr, .ext_we, .ext_wdata, .ext_rdata, .ext_ready
    );

    high_ram #(.HRAM_AW(HRAM_AW)) i_high_ram (.clk, .rst, .bus(t_hram));

    int_ctrl i_int_ctrl (.clk, .rst, .bus(t_int), .int_req, .irq, .irq_id);

    oam_dma #(.DMA_LEN(DMA_LEN)) i_oam_dma (
        .clk, .rst, .regs(t_dma), .m_dma, .dma_busy
    );

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/10ps

// Free running testbench clock
module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial clk = 1'b0;                    // First rising edge half a period in
    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// ==== bench/boy_bus_sva.sv ====
`timescale 1ns/10ps

// Handshake rules on the top-level ports
module boy_bus_sva (
    input logic               clk,
    input logic               rst,
    input logic               cpu_valid,
    input logic               cpu_ready,
    input boy_bus_pkg::addr_t cpu_addr,
    input logic               ext_valid,
    input logic               ext_ready,
    input boy_bus_pkg::addr_t ext_addr
);

    int fail_count = 0;   // Failed assertions so far

    // Processor request held until accepted
    cpu_addr_hold: assert property (@(posedge clk) disable iff (rst)
        cpu_valid && !cpu_ready |=> $stable(cpu_addr))
        else begin
            $error("cpu_addr moved while cpu_valid waited for cpu_ready");
            fail_count++;
        end

    // Cartridge side, same rule under wait states
    ext_addr_hold: assert property (@(posedge clk) disable iff (rst)
        ext_valid && !ext_ready |=> $stable(ext_addr))
        else begin
            $error("ext_addr moved while ext_valid waited for ext_ready");
            fail_count++;
        end

    // Quiet bus once reset has taken hold
    reset_quiet: assert property (@(posedge clk)
        (rst ##1 rst) |-> !cpu_ready && !ext_valid)
        else begin
            $error("cpu_ready or ext_valid high during reset");
            fail_count++;
        end

endmodule

bind boy_bus_top boy_bus_sva i_boy_bus_sva (
    .clk       (clk),
    .rst       (rst),
    .cpu_valid (cpu_valid),
    .cpu_ready (cpu_ready),
    .cpu_addr  (cpu_addr),
    .ext_valid (ext_valid),
    .ext_ready (ext_ready),
    .ext_addr  (ext_addr)
);

// ==== bench/boy_bus_tb.sv ====
`timescale 1ns/10ps

module boy_bus_tb;

    localparam int HRAM_AW  = 7;
    localparam int DMA_LEN  = 160;
    localparam int N_ACCESS = 400;     // Processor accesses over all tests, rounded up
    localparam int N_DMA    = 2;       // Copies started by the tests
    localparam int WATCHDOG_CYCLES = 2 * (N_ACCESS + N_DMA * DMA_LEN * 2 * 4);

    logic                          clk;
    logic                          rst;
    logic                          cpu_valid;
    boy_bus_pkg::addr_t            cpu_addr;
    logic                          cpu_we;
    boy_bus_pkg::data_t            cpu_wdata;
    logic                          cpu_ready;
    boy_bus_pkg::data_t            cpu_rdata;
    logic                          ext_valid;
    boy_bus_pkg::addr_t            ext_addr;
    logic                          ext_we;
    boy_bus_pkg::data_t            ext_wdata;
    boy_bus_pkg::data_t            ext_rdata;
    logic                          ext_ready;
    logic [boy_bus_pkg::INT_N-1:0] int_req;
    logic                          irq;
    logic [2:0]                    irq_id;
    logic                          dma_busy;

    // External memory model
    boy_bus_pkg::data_t ext_mem [65536];
    boy_bus_pkg::addr_t log_addr [$];  // Every completed write
    boy_bus_pkg::data_t log_data [$];
    boy_bus_pkg::addr_t srv_addr;      // Request being served
    logic               serving;
    int                 wait_left;     // Wait states still to go
    int                 ext_cycles;    // Edges with ext_valid high

    logic [31:0] lcg_state;
    int          last_wait;            // Wait cycles of the last processor transfer

    tb_clock #(.PERIOD_NS(100)) i_tb_clock (.clk(clk));

    boy_bus_top #(.HRAM_AW(HRAM_AW), .DMA_LEN(DMA_LEN)) i_boy_bus_top (.*);

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] rand_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'h0, lcg_state[31:16]};  // Upper half, low bits repeat too soon
    endfunction

    // Background pattern, every address bit takes part
    function automatic boy_bus_pkg::data_t fill_byte(input boy_bus_pkg::addr_t a);
        return (a[7:0] + {a[11:8], a[15:12]}) ^ 8'h96;
    endfunction

    // Index of the lowest set bit
    function automatic int lowest_pending(input logic [boy_bus_pkg::INT_N-1:0] m);
        for (int i = 0; i < boy_bus_pkg::INT_N; i++) begin
            if (m[i])
                return i;
        end
        return 0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // One processor transfer, entered and left on a falling edge
    task automatic bus_transfer(input boy_bus_pkg::addr_t addr, input logic we,
                                input boy_bus_pkg::data_t wdata,
                                output boy_bus_pkg::data_t rdata);
        int waits;
        waits     = 0;
        cpu_valid = 1'b1;
        cpu_addr  = addr;
        cpu_we    = we;
        cpu_wdata = wdata;
        @(posedge clk);
        while (cpu_ready !== 1'b1) begin
            waits++;                       // Edge passed without completion
            @(posedge clk);
        end
        rdata     = cpu_rdata;             // Good in the completing cycle
        last_wait = waits;
        @(negedge clk);
        cpu_valid = 1'b0;
        cpu_we    = 1'b0;
    endtask

    task automatic cpu_write(input boy_bus_pkg::addr_t addr, input boy_bus_pkg::data_t data);
        boy_bus_pkg::data_t unused;
        bus_transfer(addr, 1'b1, data, unused);
    endtask

    task automatic cpu_read(input boy_bus_pkg::addr_t addr, output boy_bus_pkg::data_t data);
        bus_transfer(addr, 1'b0, 8'h00, data);
    endtask

    // Fresh source page, OAM set to the complement so every copied byte shows
    task automatic preload_page(input boy_bus_pkg::data_t page);
        boy_bus_pkg::addr_t src;
        for (int i = 0; i < 256; i++) begin
            src = {page, 8'(i)};
            ext_mem[src] = fill_byte(src);
            ext_mem[boy_bus_pkg::OAM_BASE + 16'(i)] = ~fill_byte(src);
        end
    endtask

    task automatic wait_dma_done();
        while (dma_busy)
            @(negedge clk);                // Watchdog catches a stuck copy
    endtask

    task automatic check_copy(input boy_bus_pkg::data_t page);
        for (int i = 0; i < DMA_LEN; i++)
            check_value("oam byte", ext_mem[boy_bus_pkg::OAM_BASE + 16'(i)],
                        fill_byte({page, 8'(i)}));
        // First byte past the copy left alone
        check_value("oam past end", ext_mem[boy_bus_pkg::OAM_BASE + 16'(DMA_LEN)],
                    8'(~fill_byte({page, 8'(DMA_LEN)})));
    endtask

    //////////////////////////////////////////////////
    // External memory model
    //////////////////////////////////////////////////

    // Sample on the rising edge
    always @(posedge clk) begin
        if (ext_valid === 1'b1)
            ext_cycles++;
        if (ext_valid === 1'b1 && ext_ready) begin
            if (ext_we) begin
                ext_mem[ext_addr] = ext_wdata;
                log_addr.push_back(ext_addr);
                log_data.push_back(ext_wdata);
            end
            serving = 1'b0;
        end else if (ext_valid === 1'b1 && !serving) begin
            serving   = 1'b1;
            srv_addr  = ext_addr;
            wait_left = rand_next() % 4;   // 0 to 3 wait states
        end else if (serving && wait_left > 0) begin
            wait_left--;
        end
    end

    // Drive on the falling edge
    always @(negedge clk) begin
        if (serving && wait_left == 0) begin
            ext_ready <= 1'b1;
            ext_rdata <= ext_mem[srv_addr];
        end else begin
            ext_ready <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic reset_and_latency();
        boy_bus_pkg::data_t rd;
        @(posedge clk);
        check_value("cpu_ready", cpu_ready, 1'b0);
        check_value("ext_valid", ext_valid, 1'b0);
        check_value("irq", irq, 1'b0);
        check_value("dma_busy", dma_busy, 1'b0);
        @(negedge clk);
        cpu_write(boy_bus_pkg::HRAM_BASE, 8'h3C);
        check_value("cpu wait cycles", last_wait, 1);
        cpu_read(boy_bus_pkg::HRAM_BASE, rd);
        check_value("cpu wait cycles", last_wait, 1);
        check_value("cpu_rdata", rd, 8'h3C);
    endtask

    task automatic hram_fill_readback();
        boy_bus_pkg::data_t expect_mem [127];
        boy_bus_pkg::data_t rd;
        int                 ext_before;
        ext_before = ext_cycles;
        for (int a = 0; a < 127; a++) begin
            expect_mem[a] = 8'(rand_next());
            cpu_write(boy_bus_pkg::HRAM_BASE + 16'(a), expect_mem[a]);
        end
        for (int a = 0; a < 127; a++) begin
            cpu_read(boy_bus_pkg::HRAM_BASE + 16'(a), rd);
            check_value("cpu_rdata", rd, expect_mem[a]);
        end
        check_value("ext_valid cycles", ext_cycles, ext_before);  // Nothing went outside
    endtask

    task automatic ext_port_access();
        boy_bus_pkg::addr_t io_addr [4] = '{16'hFF01, 16'hFF40, 16'hFF47, 16'hFF7F};
        boy_bus_pkg::addr_t addr;
        boy_bus_pkg::data_t data;
        boy_bus_pkg::data_t rd;
        int                 n;
        for (int k = 0; k < 16; k++) begin
            if (k < 12)
                addr = 16'(rand_next() % 32'hFE00);  // Anywhere below OAM
            else
                addr = io_addr[k - 12];              // Unclaimed I/O slots
            data = 8'(rand_next());
            n = log_addr.size();
            cpu_write(addr, data);
            check_value("ext write count", log_addr.size(), n + 1);
            check_value("ext_addr", log_addr[n], addr);
            check_value("ext_wdata", log_data[n], data);
            data = 8'(rand_next());
            ext_mem[addr] = data;                    // New byte, read must fetch it
            cpu_read(addr, rd);
            check_value("cpu_rdata", rd, data);
        end
    endtask

    task automatic interrupt_regs();
        logic [4:0]         ie_set [7] = '{5'h1F, 5'h1F, 5'h0A, 5'h10, 5'h0F, 5'h1F, 5'h06};
        logic [4:0]         if_set [7] = '{5'h04, 5'h18, 5'h0F, 5'h1F, 5'h10, 5'h01, 5'h06};
        logic [4:0]         m;
        boy_bus_pkg::data_t rd;
        cpu_write(boy_bus_pkg::ADDR_IE, 8'hFF);
        cpu_read(boy_bus_pkg::ADDR_IE, rd);
        check_value("IE", rd, 8'h1F);                // Top bits read as zero
        cpu_write(boy_bus_pkg::ADDR_IF, 8'hE5);
        cpu_read(boy_bus_pkg::ADDR_IF, rd);
        check_value("IF", rd, 8'h05);
        cpu_write(boy_bus_pkg::ADDR_IF, 8'h00);
        check_value("irq", irq, 1'b0);
        // Single request pulse on source 2
        int_req = 5'b00100;
        @(negedge clk);
        int_req = '0;
        cpu_read(boy_bus_pkg::ADDR_IF, rd);
        check_value("IF", rd, 8'h04);
        check_value("irq", irq, 1'b1);
        check_value("irq_id", irq_id, 3'd2);
        for (int k = 0; k < 7; k++) begin
            cpu_write(boy_bus_pkg::ADDR_IE, {3'b000, ie_set[k]});
            cpu_write(boy_bus_pkg::ADDR_IF, {3'b000, if_set[k]});
            m = ie_set[k] & if_set[k];
            check_value("irq", irq, m != 0);
            if (m != 0)
                check_value("irq_id", irq_id, lowest_pending(m));
        end
        // Bits written as zero clear
        cpu_write(boy_bus_pkg::ADDR_IF, 8'h1F);
        cpu_write(boy_bus_pkg::ADDR_IF, 8'h0A);
        cpu_read(boy_bus_pkg::ADDR_IF, rd);
        check_value("IF", rd, 8'h0A);
    endtask

    task automatic dma_copy();
        boy_bus_pkg::data_t rd;
        int                 n;
        preload_page(8'hC0);
        n = log_addr.size();
        cpu_write(boy_bus_pkg::ADDR_DMA, 8'hC0);
        check_value("dma_busy", dma_busy, 1'b1);     // Up right after the write
        cpu_read(boy_bus_pkg::ADDR_DMA, rd);
        check_value("dma source", rd, 8'hC0);
        wait_dma_done();
        // Busy held until every OAM write went out
        check_value("dma write count", log_addr.size(), n + DMA_LEN);
        check_copy(8'hC0);
    endtask

    task automatic dma_with_cpu_traffic();
        boy_bus_pkg::addr_t addr;
        boy_bus_pkg::data_t data;
        boy_bus_pkg::data_t rd;
        preload_page(8'hC1);
        cpu_write(boy_bus_pkg::ADDR_DMA, 8'hC1);
        for (int k = 0; k < 24; k++) begin
            check_value("dma_busy", dma_busy, 1'b1);  // Still copying
            addr = boy_bus_pkg::HRAM_BASE + 16'(rand_next() % 127);
            data = 8'(rand_next());
            cpu_write(addr, data);
            cpu_read(addr, rd);
            check_value("cpu_rdata", rd, data);
        end
        wait_dma_done();
        check_copy(8'hC1);
    endtask

    //////////////////////////////////////////////////
    // Run
    //////////////////////////////////////////////////

    initial begin
        lcg_state   = 32'd98445;
        last_wait   = 0;
        serving     = 1'b0;
        wait_left   = 0;
        ext_cycles  = 0;
        srv_addr    = '0;
        ext_ready   = 1'b0;
        ext_rdata   = '0;
        rst         = 1'b1;
        cpu_valid   = 1'b0;
        cpu_addr    = '0;
        cpu_we      = 1'b0;
        cpu_wdata   = '0;
        int_req     = '0;
        for (int a = 0; a < 65536; a++)
            ext_mem[a] = fill_byte(16'(a));
        repeat (2) @(negedge clk);         // Two rising edges in reset
        rst = 1'b0;
        reset_and_latency();
        hram_fill_readback();
        ext_port_access();
        interrupt_regs();
        dma_copy();
        dma_with_cpu_traffic();
        if (i_boy_bus_top.i_boy_bus_sva.fail_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    // Bound handshake checks
    initial begin
        wait (i_boy_bus_top.i_boy_bus_sva.fail_count != 0);
        $display("A handshake assertion on the DUT ports failed");
        $display("Testbench failed");
        $fatal(1, "Assertion failure");
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Run timed out after %0d clock cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== tb.f ====
src/boy_bus_pkg.sv
src/sys_bus_if.sv
src/bus_arbiter.sv
src/bus_decoder.sv
src/high_ram.sv
src/int_ctrl.sv
src/oam_dma.sv
src/boy_bus_top.sv
bench/tb_clock.sv
bench/boy_bus_sva.sv
bench/boy_bus_tb.sv

// ==== Bender.yml ====
package:
  name: boy_bus

sources:
  - src/boy_bus_pkg.sv
  - src/sys_bus_if.sv
  - src/bus_arbiter.sv
  - src/bus_decoder.sv
  - src/high_ram.sv
  - src/int_ctrl.sv
  - src/oam_dma.sv
  - src/boy_bus_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/boy_bus_sva.sv
      - bench/boy_bus_tb.sv
